// File: list.f
logic/axi_mem_pkg.sv
logic/user_flag_pkg.sv
logic/resp_meta_if.sv
logic/resp_meta_fifo.sv
logic/axi_user_ext_merge.sv
logic/axi_mem_user_ext.sv
testbench/axi_mem_user_ext_props.sv
testbench/axi_mem_user_ext_tb.sv

// File: Bender.yml
package:
  name: axi_mem_user_ext

sources:
  - logic/axi_mem_pkg.sv
  - logic/user_flag_pkg.sv
  - logic/resp_meta_if.sv
  - logic/resp_meta_fifo.sv
  - logic/axi_user_ext_merge.sv
  - logic/axi_mem_user_ext.sv
  - target: test
    files:
      - testbench/axi_mem_user_ext_props.sv
      - testbench/axi_mem_user_ext_tb.sv

// File: testbench/axi_mem_user_ext_tb.sv
// Testbench with stimulus table, source and in-order sink models, value checks and watchdog
module axi_mem_user_ext_tb;

    localparam int FIM_USER_WIDTH = 4;
    localparam int NUM_ROWS = 13;
    // Rows from here on fill the read FIFO to exercise back-pressure
    localparam int MAIN_ROWS = 8;
    localparam int SID_W = axi_mem_pkg::SINK_ID_WIDTH;

    // One request plus the low ID bits that the sink model hands back
    typedef struct packed {
        logic                  is_write;
        axi_mem_pkg::src_id_t  id;
        axi_mem_pkg::user_t    user;
        logic [3:0]            len;
        axi_mem_pkg::sink_id_t low;
    } row_t;

    logic clk = 1'b0;
    logic rst;
    logic src_arvalid, src_arready, src_rvalid, src_rready, src_rlast;
    logic src_awvalid, src_awready, src_wvalid, src_wready, src_wlast, src_bvalid, src_bready;
    logic sink_arvalid, sink_arready, sink_rvalid, sink_rready, sink_rlast;
    logic sink_awvalid, sink_awready, sink_wvalid, sink_wready, sink_wlast;
    logic sink_bvalid, sink_bready;
    axi_mem_pkg::src_id_t      src_arid, src_rid, src_awid, src_bid;
    axi_mem_pkg::sink_id_t     sink_arid, sink_rid, sink_awid, sink_bid;
    axi_mem_pkg::addr_t        src_araddr, src_awaddr, sink_araddr, sink_awaddr;
    axi_mem_pkg::data_t        src_rdata, src_wdata, sink_rdata, sink_wdata;
    axi_mem_pkg::user_t        src_aruser, src_ruser, src_awuser, src_buser;
    logic [FIM_USER_WIDTH-1:0] sink_aruser, sink_awuser;

    row_t rows [NUM_ROWS];
    // Requests taken by the shim and answered by the sink model oldest first
    int   rd_pending [$];
    int   wr_pending [$];

    always #4 clk = ~clk;

    axi_mem_user_ext #(
        .FIM_USER_WIDTH (FIM_USER_WIDTH),
        .RD_ENTRIES     (4),
        .WR_ENTRIES     (4)
    ) axi_mem_user_ext_inst (.*);

    // The properties watch the merge block from inside the DUT
    bind axi_user_ext_merge axi_mem_user_ext_props #(
        .RD_ENTRIES (4)
    ) props_inst (
        .clk          (clk),
        .rst          (rst),
        .src_arvalid  (src_arvalid),
        .src_arready  (src_arready),
        .sink_arvalid (sink_arvalid),
        .rd_enq       (rd.enq),
        .rd_deq       (rd.deq),
        .wr_enq       (wr.enq),
        .wr_deq       (wr.deq)
    );

    // Galois LFSR that is stepped once per stimulus bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Response ID keeps the request's high bits and takes the sink's low bits
    function automatic axi_mem_pkg::src_id_t expected_resp_id(input int idx);
        return {rows[idx].id[axi_mem_pkg::SRC_ID_WIDTH-1:SID_W], rows[idx].low};
    endfunction

    // The device sees only the flags above the local ones
    function automatic axi_mem_pkg::user_t expected_sink_user(input int idx);
        return axi_mem_pkg::user_t'(
            rows[idx].user[user_flag_pkg::DEV_FLAG_START +: FIM_USER_WIDTH]);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_src_id(input string name, input axi_mem_pkg::src_id_t got,
                                input axi_mem_pkg::src_id_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_sink_id(input string name, input axi_mem_pkg::sink_id_t got,
                                 input axi_mem_pkg::sink_id_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_user(input string name, input axi_mem_pkg::user_t got,
                              input axi_mem_pkg::user_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input axi_mem_pkg::addr_t got,
                              input axi_mem_pkg::addr_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_data(input string name, input axi_mem_pkg::data_t got,
                              input axi_mem_pkg::data_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    // Kind, source ID, user and burst length are fixed while the sink low ID bits are random
    task automatic fill_table();
        logic [31:0] lfsr;
        lfsr = 32'hc7bddbd4;
        rows[0]  = '{1'b0, 6'h2a, 8'h9d, 4'd1, 4'h0};
        rows[1]  = '{1'b0, 6'h17, 8'h63, 4'd3, 4'h0};
        rows[2]  = '{1'b0, 6'h3c, 8'hf2, 4'd1, 4'h0};
        rows[3]  = '{1'b0, 6'h05, 8'h4e, 4'd2, 4'h0};
        rows[4]  = '{1'b1, 6'h31, 8'hb7, 4'd2, 4'h0};
        rows[5]  = '{1'b1, 6'h0e, 8'h29, 4'd1, 4'h0};
        rows[6]  = '{1'b1, 6'h23, 8'hd4, 4'd3, 4'h0};
        rows[7]  = '{1'b1, 6'h18, 8'h7a, 4'd1, 4'h0};
        rows[8]  = '{1'b0, 6'h39, 8'h1b, 4'd1, 4'h0};
        rows[9]  = '{1'b0, 6'h26, 8'hc5, 4'd2, 4'h0};
        rows[10] = '{1'b0, 6'h0b, 8'h6f, 4'd1, 4'h0};
        rows[11] = '{1'b0, 6'h34, 8'ha8, 4'd1, 4'h0};
        rows[12] = '{1'b0, 6'h1d, 8'h56, 4'd2, 4'h0};
        for (int r = 0; r < NUM_ROWS; r++)
            for (int b = 0; b < SID_W; b++)
            begin
                lfsr = lfsr_next(lfsr);
                rows[r].low[b] = lfsr[0];
            end
    endtask

    task automatic drive_ar(input int idx);
        @(posedge clk);
        src_arvalid <= 1'b1;
        src_arid    <= rows[idx].id;
        src_araddr  <= axi_mem_pkg::addr_t'(idx * 16);
        src_aruser  <= rows[idx].user;
    endtask

    // Waits for the shim to take the read, checks what reached the sink and records it
    task automatic wait_ar_accept(input int idx);
        @(negedge clk);
        while (!src_arready)
            @(negedge clk);
        check_flag("sink_arvalid", sink_arvalid, 1'b1);
        check_sink_id("sink_arid", sink_arid, rows[idx].id[SID_W-1:0]);
        check_addr("sink_araddr", sink_araddr, axi_mem_pkg::addr_t'(idx * 16));
        check_user("sink_aruser", axi_mem_pkg::user_t'(sink_aruser), expected_sink_user(idx));
        rd_pending.push_back(idx);
        @(posedge clk);
        src_arvalid <= 1'b0;
    endtask

    // Write address followed by its data beats straight through to the sink
    task automatic issue_write(input int idx);
        @(posedge clk);
        src_awvalid <= 1'b1;
        src_awid    <= rows[idx].id;
        src_awaddr  <= axi_mem_pkg::addr_t'(idx * 16);
        src_awuser  <= rows[idx].user;
        @(negedge clk);
        while (!src_awready)
            @(negedge clk);
        check_flag("sink_awvalid", sink_awvalid, 1'b1);
        check_sink_id("sink_awid", sink_awid, rows[idx].id[SID_W-1:0]);
        check_addr("sink_awaddr", sink_awaddr, axi_mem_pkg::addr_t'(idx * 16));
        check_user("sink_awuser", axi_mem_pkg::user_t'(sink_awuser), expected_sink_user(idx));
        wr_pending.push_back(idx);
        for (int beat = 0; beat < int'(rows[idx].len); beat++)
        begin
            @(posedge clk);
            src_awvalid <= 1'b0;
            src_wvalid  <= 1'b1;
            src_wdata   <= axi_mem_pkg::data_t'(idx * 256 + beat);
            src_wlast   <= (beat == int'(rows[idx].len) - 1);
            @(negedge clk);
            check_flag("sink_wvalid", sink_wvalid, 1'b1);
            check_flag("src_wready", src_wready, 1'b1);
            check_data("sink_wdata", sink_wdata, axi_mem_pkg::data_t'(idx * 256 + beat));
            check_flag("sink_wlast", sink_wlast, beat == int'(rows[idx].len) - 1);
        end
        @(posedge clk);
        src_wvalid <= 1'b0;
    endtask

    // Sink model returns one read burst and every beat carries its request's metadata
    task automatic respond_read(input int idx);
        for (int beat = 0; beat < int'(rows[idx].len); beat++)
        begin
            @(posedge clk);
            sink_rvalid <= 1'b1;
            sink_rid    <= rows[idx].low;
            sink_rdata  <= axi_mem_pkg::data_t'(idx * 256 + beat);
            sink_rlast  <= (beat == int'(rows[idx].len) - 1);
            @(negedge clk);
            check_flag("src_rvalid", src_rvalid, 1'b1);
            check_flag("sink_rready", sink_rready, 1'b1);
            check_src_id("src_rid", src_rid, expected_resp_id(idx));
            check_data("src_rdata", src_rdata, axi_mem_pkg::data_t'(idx * 256 + beat));
            check_flag("src_rlast", src_rlast, beat == int'(rows[idx].len) - 1);
            check_user("src_ruser", src_ruser, rows[idx].user);
        end
    endtask

    task automatic stop_reads();
        @(posedge clk);
        sink_rvalid <= 1'b0;
        sink_rlast  <= 1'b0;
    endtask

    task automatic drain_reads();
        while (rd_pending.size() > 0)
            respond_read(rd_pending.pop_front());
        stop_reads();
    endtask

    // One B per write with no gap between them
    task automatic drain_writes();
        int idx;
        while (wr_pending.size() > 0)
        begin
            idx = wr_pending.pop_front();
            @(posedge clk);
            sink_bvalid <= 1'b1;
            sink_bid    <= rows[idx].low;
            @(negedge clk);
            check_flag("src_bvalid", src_bvalid, 1'b1);
            check_flag("sink_bready", sink_bready, 1'b1);
            check_src_id("src_bid", src_bid, expected_resp_id(idx));
            check_user("src_buser", src_buser, rows[idx].user);
        end
        @(posedge clk);
        sink_bvalid <= 1'b0;
    endtask

    initial
    begin
        rst = 1'b1;
        {src_arvalid, src_awvalid, src_wvalid, src_wlast} = '0;
        {sink_rvalid, sink_rlast, sink_bvalid} = '0;
        {src_rready, src_bready, sink_arready, sink_awready, sink_wready} = '1;
        {src_arid, src_awid, sink_rid, sink_bid} = '0;
        {src_araddr, src_awaddr, src_aruser, src_awuser} = '0;
        {src_wdata, sink_rdata} = '0;
        fill_table();
        repeat (5)
            @(posedge clk);
        rst <= 1'b0;

        // Four reads including a three-beat burst and then four writes kept outstanding
        for (int i = 0; i < MAIN_ROWS; i++)
        begin
            if (rows[i].is_write)
                issue_write(i);
            else
            begin
                drive_ar(i);
                wait_ar_accept(i);
            end
            if (i % 4 == 3)
            begin
                drain_reads();
                drain_writes();
            end
        end

        // Four reads fill the read FIFO while the sink withholds its responses
        for (int i = MAIN_ROWS; i < NUM_ROWS - 1; i++)
        begin
            drive_ar(i);
            wait_ar_accept(i);
        end
        // A fifth read has to wait although the sink itself is ready
        drive_ar(NUM_ROWS - 1);
        repeat (6)
        begin
            @(negedge clk);
            check_flag("sink_arvalid", sink_arvalid, 1'b1);
            check_flag("src_arready", src_arready, 1'b0);
        end
        // Retiring the oldest read frees exactly one entry
        respond_read(rd_pending.pop_front());
        stop_reads();
        wait_ar_accept(NUM_ROWS - 1);
        drain_reads();

        $display("all tests passed");
        $finish;
    end

    // Generous bound of 200 cycles per table row
    initial
    begin
        repeat (NUM_ROWS * 200)
            @(posedge clk);
        abort_run("Timed out because the DUT stopped completing handshakes");
    end

endmodule

// File: testbench/axi_mem_user_ext_props.sv
// Concurrent assertions on the merge block for ready gating, dequeue legality and AR valid
module axi_mem_user_ext_props #(
    // Depth of the read FIFO behind the merge block
    parameter int RD_ENTRIES = 4
) (
    input logic clk,
    input logic rst,
    input logic src_arvalid,
    input logic src_arready,
    input logic sink_arvalid,
    input logic rd_enq,
    input logic rd_deq,
    input logic wr_enq,
    input logic wr_deq
);

    // Requests recorded and not yet retired on each channel
    int rd_open;
    int wr_open;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_open <= 0;
            wr_open <= 0;
        end
        else
        begin
            rd_open <= rd_open + int'(rd_enq) - int'(rd_deq);
            wr_open <= wr_open + int'(wr_enq) - int'(wr_deq);
        end
    end

    // With every read entry in use the source address must be held back
    a_arready_gated: assert property (@(posedge clk) disable iff (rst)
        rd_open >= RD_ENTRIES |-> !src_arready)
        else $error("source arready high while every read entry is in use");

    a_rd_deq_open: assert property (@(posedge clk) disable iff (rst) rd_deq |-> rd_open > 0)
        else $error("read dequeue with no outstanding request");

    a_wr_deq_open: assert property (@(posedge clk) disable iff (rst) wr_deq |-> wr_open > 0)
        else $error("write dequeue with no outstanding request");

    // AR valid is passed down unchanged
    a_arvalid_mirror: assert property (@(posedge clk) disable iff (rst)
        sink_arvalid == src_arvalid)
        else $error("sink arvalid differs from source arvalid");

endmodule

// File: logic/axi_mem_user_ext.sv
// AXI memory user and ID extension shim: two metadata FIFOs and the merge block
module axi_mem_user_ext #(
    // Width of the device flags the sink accepts
    parameter int FIM_USER_WIDTH = 4,
    // Outstanding reads and writes that can be tracked
    parameter int RD_ENTRIES = 16,
    parameter int WR_ENTRIES = 16
) (
    input  logic                        clk,
    input  logic                        rst,

    // Accelerator-side master
    input  logic                        src_arvalid,
    output logic                        src_arready,
    input  axi_mem_pkg::src_id_t        src_arid,
    input  axi_mem_pkg::addr_t          src_araddr,
    input  axi_mem_pkg::user_t          src_aruser,
    output logic                        src_rvalid,
    input  logic                        src_rready,
    output axi_mem_pkg::src_id_t        src_rid,
    output axi_mem_pkg::data_t          src_rdata,
    output logic                        src_rlast,
    output axi_mem_pkg::user_t          src_ruser,

    input  logic                        src_awvalid,
    output logic                        src_awready,
    input  axi_mem_pkg::src_id_t        src_awid,
    input  axi_mem_pkg::addr_t          src_awaddr,
    input  axi_mem_pkg::user_t          src_awuser,
    input  logic                        src_wvalid,
    output logic                        src_wready,
    input  axi_mem_pkg::data_t          src_wdata,
    input  logic                        src_wlast,
    output logic                        src_bvalid,
    input  logic                        src_bready,
    output axi_mem_pkg::src_id_t        src_bid,
    output axi_mem_pkg::user_t          src_buser,

    // Native memory device
    output logic                        sink_arvalid,
    input  logic                        sink_arready,
    output axi_mem_pkg::sink_id_t       sink_arid,
    output axi_mem_pkg::addr_t          sink_araddr,
    output logic [FIM_USER_WIDTH-1:0]   sink_aruser,
    input  logic                        sink_rvalid,
    output logic                        sink_rready,
    input  axi_mem_pkg::sink_id_t       sink_rid,
    input  axi_mem_pkg::data_t          sink_rdata,
    input  logic                        sink_rlast,

    output logic                        sink_awvalid,
    input  logic                        sink_awready,
    output axi_mem_pkg::sink_id_t       sink_awid,
    output axi_mem_pkg::addr_t          sink_awaddr,
    output logic [FIM_USER_WIDTH-1:0]   sink_awuser,
    output logic                        sink_wvalid,
    input  logic                        sink_wready,
    output axi_mem_pkg::data_t          sink_wdata,
    output logic                        sink_wlast,
    input  logic                        sink_bvalid,
    output logic                        sink_bready,
    input  axi_mem_pkg::sink_id_t       sink_bid
);

    // One metadata link per channel
    resp_meta_if #(.ENTRIES(RD_ENTRIES)) rd_meta ();
    resp_meta_if #(.ENTRIES(WR_ENTRIES)) wr_meta ();

    // Read requests retire when their last R beat is taken
    resp_meta_fifo #(
        .ENTRIES (RD_ENTRIES)
    ) rd_fifo (
        .clk  (clk),
        .rst  (rst),
        .meta (rd_meta.store)
    );

    // Write requests retire with their B response
    resp_meta_fifo #(
        .ENTRIES (WR_ENTRIES)
    ) wr_fifo (
        .clk  (clk),
        .rst  (rst),
        .meta (wr_meta.store)
    );

    // All AXI channel ports share names with the top level
    axi_user_ext_merge #(
        .FIM_USER_WIDTH (FIM_USER_WIDTH)
    ) merge (
        .rd (rd_meta.track),
        .wr (wr_meta.track),
        .*
    );

endmodule

// File: logic/axi_user_ext_merge.sv
// Channel wiring, ready gating, user forwarding and response ID/user rebuild
module axi_user_ext_merge #(
    // Width of the device flags carried by the sink user field
    parameter int FIM_USER_WIDTH = 4
) (
    // Clock and reset of the shim; this block's own paths are combinational
    input  logic                        clk,
    input  logic                        rst,

    resp_meta_if.track                  rd,
    resp_meta_if.track                  wr,

    // Source AR and R
    input  logic                        src_arvalid,
    output logic                        src_arready,
    input  axi_mem_pkg::src_id_t        src_arid,
    input  axi_mem_pkg::addr_t          src_araddr,
    input  axi_mem_pkg::user_t          src_aruser,
    output logic                        src_rvalid,
    input  logic                        src_rready,
    output axi_mem_pkg::src_id_t        src_rid,
    output axi_mem_pkg::data_t          src_rdata,
    output logic                        src_rlast,
    output axi_mem_pkg::user_t          src_ruser,

    // Source AW, W and B
    input  logic                        src_awvalid,
    output logic                        src_awready,
    input  axi_mem_pkg::src_id_t        src_awid,
    input  axi_mem_pkg::addr_t          src_awaddr,
    input  axi_mem_pkg::user_t          src_awuser,
    input  logic                        src_wvalid,
    output logic                        src_wready,
    input  axi_mem_pkg::data_t          src_wdata,
    input  logic                        src_wlast,
    output logic                        src_bvalid,
    input  logic                        src_bready,
    output axi_mem_pkg::src_id_t        src_bid,
    output axi_mem_pkg::user_t          src_buser,

    // Sink AR and R
    output logic                        sink_arvalid,
    input  logic                        sink_arready,
    output axi_mem_pkg::sink_id_t       sink_arid,
    output axi_mem_pkg::addr_t          sink_araddr,
    output logic [FIM_USER_WIDTH-1:0]   sink_aruser,
    input  logic                        sink_rvalid,
    output logic                        sink_rready,
    input  axi_mem_pkg::sink_id_t       sink_rid,
    input  axi_mem_pkg::data_t          sink_rdata,
    input  logic                        sink_rlast,

    // Sink AW, W and B
    output logic                        sink_awvalid,
    input  logic                        sink_awready,
    output axi_mem_pkg::sink_id_t       sink_awid,
    output axi_mem_pkg::addr_t          sink_awaddr,
    output logic [FIM_USER_WIDTH-1:0]   sink_awuser,
    output logic                        sink_wvalid,
    input  logic                        sink_wready,
    output axi_mem_pkg::data_t          sink_wdata,
    output logic                        sink_wlast,
    input  logic                        sink_bvalid,
    output logic                        sink_bready,
    input  axi_mem_pkg::sink_id_t       sink_bid
);

    localparam int SID_W = axi_mem_pkg::SINK_ID_WIDTH;
    localparam int DEV_LO = user_flag_pkg::DEV_FLAG_START;

    axi_mem_pkg::src_id_t merged_rid;
    axi_mem_pkg::src_id_t merged_bid;

    // Requests go down with the ID cut to the device width and only the
    // device flag slice of the user. A request is held back while its
    // FIFO has no room to record it
    assign sink_arvalid = src_arvalid;
    assign src_arready  = sink_arready && rd.not_full;
    assign sink_arid    = src_arid[SID_W-1:0];
    assign sink_araddr  = src_araddr;
    assign sink_aruser  = src_aruser[DEV_LO +: FIM_USER_WIDTH];

    assign sink_awvalid = src_awvalid;
    assign src_awready  = sink_awready && wr.not_full;
    assign sink_awid    = src_awid[SID_W-1:0];
    assign sink_awaddr  = src_awaddr;
    assign sink_awuser  = src_awuser[DEV_LO +: FIM_USER_WIDTH];

    // Write data beats carry no metadata
    assign sink_wvalid = src_wvalid;
    assign src_wready  = sink_wready;
    assign sink_wdata  = src_wdata;
    assign sink_wlast  = src_wlast;

    // Record full ID and user on every accepted address
    assign rd.enq      = src_arvalid && src_arready;
    assign rd.enq_id   = src_arid;
    assign rd.enq_user = src_aruser;
    assign wr.enq      = src_awvalid && src_awready;
    assign wr.enq_id   = src_awid;
    assign wr.enq_user = src_awuser;

    // A read entry retires on its last beat, so all beats share one head
    assign rd.deq = src_rvalid && src_rready && src_rlast;
    assign wr.deq = src_bvalid && src_bready;

    // High ID bits come from the FIFO, low bits from the device
    always_comb
    begin
        merged_rid = rd.head_id;
        merged_rid[SID_W-1:0] = sink_rid;
        merged_bid = wr.head_id;
        merged_bid[SID_W-1:0] = sink_bid;
    end

    assign src_rvalid  = sink_rvalid;
    assign sink_rready = src_rready;
    assign src_rid     = merged_rid;
    assign src_rdata   = sink_rdata;
    assign src_rlast   = sink_rlast;
    assign src_ruser   = rd.head_user;

    assign src_bvalid  = sink_bvalid;
    assign sink_bready = src_bready;
    assign src_bid     = merged_bid;
    assign src_buser   = wr.head_user;

endmodule

// File: logic/resp_meta_fifo.sv
// In-order FIFO holding the source ID and user of each outstanding request
module resp_meta_fifo #(
    parameter int ENTRIES = 16
) (
    input logic          clk,
    input logic          rst,
    resp_meta_if.store   meta
);

    localparam int PTR_WIDTH = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
    localparam int CNT_WIDTH = $clog2(ENTRIES + 1);
    localparam int ENTRY_WIDTH = axi_mem_pkg::SRC_ID_WIDTH + axi_mem_pkg::USER_WIDTH;

    typedef logic [PTR_WIDTH-1:0]   ptr_t;
    typedef logic [CNT_WIDTH-1:0]   count_t;
    typedef logic [ENTRY_WIDTH-1:0] entry_t;

    // Each entry is { id, user } of one request
    entry_t mem [ENTRIES];

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;

    logic   do_enq;
    logic   do_deq;

    // Pointers wrap at ENTRIES, which need not be a power of two
    function automatic ptr_t next_ptr(input ptr_t p);
        ptr_t n;
        if (p == ptr_t'(ENTRIES - 1))
            n = '0;
        else
            n = p + 1'b1;
        return n;
    endfunction

    // A push while full or a pop while empty is dropped
    assign do_enq = meta.enq && meta.not_full;
    assign do_deq = meta.deq && (count != '0);

    assign meta.not_full = (count != count_t'(ENTRIES));

    // Head shows the oldest entry; stale data while empty is never consumed
    assign {meta.head_id, meta.head_user} = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_enq)
            mem[wr_ptr] <= {meta.enq_id, meta.enq_user};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_enq)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_deq)
                rd_ptr <= next_ptr(rd_ptr);

            // Occupancy holds when a push and a pop meet in one cycle
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: logic/resp_meta_if.sv
// Metadata FIFO link: enqueue side and head between a FIFO and the merge block
interface resp_meta_if #(
    // Depth of the FIFO behind this link
    parameter int ENTRIES = 16
);

    // Enqueue side, pulsed on an accepted address handshake
    logic                     enq;
    axi_mem_pkg::src_id_t     enq_id;
    axi_mem_pkg::user_t       enq_user;

    // Level, high while at least one entry is free
    logic                     not_full;

    // Oldest outstanding request and its release strobe
    axi_mem_pkg::src_id_t     head_id;
    axi_mem_pkg::user_t       head_user;
    logic                     deq;

    // FIFO side
    modport store (
        input  enq, enq_id, enq_user, deq,
        output not_full, head_id, head_user
    );

    // Merge block side
    modport track (
        output enq, enq_id, enq_user, deq,
        input  not_full, head_id, head_user
    );

endinterface

// File: logic/user_flag_pkg.sv
// Layout of the source user field: shim-local flags and device flags
package user_flag_pkg;

    // The user field is laid out as { device flags, local flags }.
    // Local flags steer behaviour inside the shim only and are
    // handed back to the source with the response

    // Number of low user bits that never reach the device
    localparam int LOCAL_FLAG_WIDTH = 2;

    // First user bit that is forwarded to the device
    localparam int DEV_FLAG_START = LOCAL_FLAG_WIDTH;

    // Vector holding the local flag bits alone
    typedef logic [LOCAL_FLAG_WIDTH-1:0] local_flags_t;

endpackage

// File: logic/axi_mem_pkg.sv
// AXI field widths and vector types for IDs, addresses, data and user fields
package axi_mem_pkg;

    // The accelerator side issues IDs wider than the device can carry
    localparam int SRC_ID_WIDTH = 6;

    // The native device returns only this many low ID bits
    localparam int SINK_ID_WIDTH = 4;

    // Full user width seen on the accelerator side
    localparam int USER_WIDTH = 8;

    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;

    // Source-side transaction ID, returned intact with each response
    typedef logic [SRC_ID_WIDTH-1:0] src_id_t;

    // Device-side transaction ID, the low part of src_id_t
    typedef logic [SINK_ID_WIDTH-1:0] sink_id_t;

    // Source-side user field, local flags in the low bits
    typedef logic [USER_WIDTH-1:0] user_t;

    // Byte address, forwarded unchanged
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // One beat of read or write data
    typedef logic [DATA_WIDTH-1:0] data_t;

endpackage
